/* Bender.yml */
package:
  name: inst_decode

sources:
  - files:
      - source/decodePkg.sv
      - source/moveArithDecode.sv
      - source/skipJumpDecode.sv
      - source/booleanDecode.sv
      - source/bitTestDecode.sv
      - source/ioDecode.sv
      - source/decodeOutputReg.sv
      - source/instDecode.sv
  - target: simulation
    files:
      - verification/instDecodeSva.sv
      - verification/instDecodeTb.sv

/* instDecode.f */
source/decodePkg.sv
source/moveArithDecode.sv
source/skipJumpDecode.sv
source/booleanDecode.sv
source/bitTestDecode.sv
source/ioDecode.sv
source/decodeOutputReg.sv
source/instDecode.sv
verification/instDecodeSva.sv
verification/instDecodeTb.sv

/* source/bitTestDecode.sv */
////////////////////////////////////////////////////////////////////////////
// Decoder for the logical test family, 600 to 677
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module bitTestDecode (
	input  decodePkg::instWord inst,
	output logic [decodePkg::dispWidth-1:0] dispatch,
	output logic [decodePkg::aluWidth-1:0] aluOp,
	output logic [decodePkg::numFlags-1:0] flags,
	output logic [decodePkg::condWidth-1:0] condCode
);
	import decodePkg::*;

	logic [1:0] modify;

	assign modify = inst.basic.opcode[5:4];            // N Z C O
	assign dispatch = dispTest;
	assign condCode = {inst.basic.opcode[2:1], 1'b0};  // never E A N become 0 2 4 6

	always_comb begin
		flags = '0;
		flags[flMSwap] = inst.basic.opcode[0];         // L and S masks use the swapped half
		flags[flReadE] = inst.basic.opcode[3];         // D and S masks come from memory
		flags[flWriteAC] = (modify != 2'd0);
		case (modify)
			2'd0: aluOp = aluSeta;                     // Test only, AC unchanged
			2'd1: aluOp = aluAndcm;                    // Zeros in masked bits
			2'd2: aluOp = aluXor;                      // Complement
			default: aluOp = aluIor;                   // Ones
		endcase
	end

endmodule

/* source/booleanDecode.sv */
////////////////////////////////////////////////////////////////////////////
// Decoder for the sixteen boolean functions, 400 to 477
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module booleanDecode (
	input  decodePkg::instWord inst,
	output logic [decodePkg::dispWidth-1:0] dispatch,
	output logic [decodePkg::aluWidth-1:0] aluOp,
	output logic [decodePkg::numFlags-1:0] flags,
	output logic [decodePkg::condWidth-1:0] condCode
);
	import decodePkg::*;

	logic [1:0] mode;

	assign mode = inst.basic.opcode[1:0];
	assign dispatch = dispCommon;
	assign aluOp = {1'b0, inst.basic.opcode[5:2]};     // Function field is the ALU code
	assign condCode = skipNever;

	// Processor flags are left alone by the boolean group
	always_comb begin
		flags = '0;
		flags[flReadE] = (mode != modeImm);
		flags[flWriteE] = (mode == modeMem) || (mode == modeBoth);
		flags[flWriteAC] = (mode != modeMem);
	end

endmodule

/* source/decodeOutputReg.sv */
////////////////////////////////////////////////////////////////////////////
// Family select by top opcode digit, control register and valid pulse
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module decodeOutputReg (
	input  logic clk,
	input  logic rstN,
	input  logic instLoad,
	input  decodePkg::instWord inst,
	input  logic [decodePkg::dispWidth-1:0] maDispatch,
	input  logic [decodePkg::aluWidth-1:0] maAluOp,
	input  logic [decodePkg::numFlags-1:0] maFlags,
	input  logic [decodePkg::condWidth-1:0] maCondCode,
	input  logic [decodePkg::dispWidth-1:0] sjDispatch,
	input  logic [decodePkg::aluWidth-1:0] sjAluOp,
	input  logic [decodePkg::numFlags-1:0] sjFlags,
	input  logic [decodePkg::condWidth-1:0] sjCondCode,
	input  logic [decodePkg::dispWidth-1:0] blDispatch,
	input  logic [decodePkg::aluWidth-1:0] blAluOp,
	input  logic [decodePkg::numFlags-1:0] blFlags,
	input  logic [decodePkg::condWidth-1:0] blCondCode,
	input  logic [decodePkg::dispWidth-1:0] btDispatch,
	input  logic [decodePkg::aluWidth-1:0] btAluOp,
	input  logic [decodePkg::numFlags-1:0] btFlags,
	input  logic [decodePkg::condWidth-1:0] btCondCode,
	input  logic [decodePkg::dispWidth-1:0] ioDispatch,
	input  logic [decodePkg::aluWidth-1:0] ioAluOp,
	input  logic [decodePkg::numFlags-1:0] ioFlags,
	input  logic [decodePkg::condWidth-1:0] ioCondCode,
	output logic decodeValid,
	output logic [decodePkg::dispWidth-1:0] dispatch,
	output logic [decodePkg::aluWidth-1:0] aluOp,
	output logic readE,
	output logic readAC,
	output logic readOne,
	output logic readMinusOne,
	output logic mSwap,
	output logic setFlags,
	output logic writeE,
	output logic writeAC,
	output logic writeSelf,
	output logic [decodePkg::condWidth-1:0] condCode,
	output logic comp0,
	output logic jump,
	output logic ioConditions
);
	import decodePkg::*;

	logic [2:0] topDigit;
	logic [dispWidth-1:0] selDispatch;
	logic [aluWidth-1:0] selAluOp;
	logic [numFlags-1:0] selFlags;
	logic [condWidth-1:0] selCondCode;
	logic [numFlags-1:0] flagsQ;

	assign topDigit = inst.basic.opcode[opWidth-1:opWidth-3];

	always_comb begin
		selDispatch = dispUnassigned;                  // Constant bundle for 1xx and 5xx
		selAluOp = aluSetz;
		selFlags = '0;
		selCondCode = skipNever;
		case (topDigit)
			topUuo: selDispatch = dispMuuo;
			topFloat, topHalfWord: selDispatch = dispUnassigned;
			topMoveArith: begin
				selDispatch = maDispatch;
				selAluOp = maAluOp;
				selFlags = maFlags;
				selCondCode = maCondCode;
			end
			topSkipJump: begin
				selDispatch = sjDispatch;
				selAluOp = sjAluOp;
				selFlags = sjFlags;
				selCondCode = sjCondCode;
			end
			topBoolean: begin
				selDispatch = blDispatch;
				selAluOp = blAluOp;
				selFlags = blFlags;
				selCondCode = blCondCode;
			end
			topTest: begin
				selDispatch = btDispatch;
				selAluOp = btAluOp;
				selFlags = btFlags;
				selCondCode = btCondCode;
			end
			ioGroup: begin
				selDispatch = ioDispatch;
				selAluOp = ioAluOp;
				selFlags = ioFlags;
				selCondCode = ioCondCode;
			end
			default: selDispatch = dispUnassigned;
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			decodeValid <= 1'b0;
			dispatch <= dispCommon;
			aluOp <= aluSetz;
			flagsQ <= '0;
			condCode <= skipNever;
		end else begin
			decodeValid <= instLoad;                   // Pulse in the cycle after each load
			if (instLoad) begin                        // Held until the next load
				dispatch <= selDispatch;
				aluOp <= selAluOp;
				flagsQ <= selFlags;
				condCode <= selCondCode;
			end
		end
	end

	assign readE = flagsQ[flReadE];
	assign readAC = flagsQ[flReadAC];
	assign readOne = flagsQ[flReadOne];
	assign readMinusOne = flagsQ[flReadMinusOne];
	assign mSwap = flagsQ[flMSwap];
	assign setFlags = flagsQ[flSetFlags];
	assign writeE = flagsQ[flWriteE];
	assign writeAC = flagsQ[flWriteAC];
	assign writeSelf = flagsQ[flWriteSelf];
	assign comp0 = flagsQ[flComp0];
	assign jump = flagsQ[flJump];
	assign ioConditions = flagsQ[flIoCond];

endmodule

/* source/decodePkg.sv */
////////////////////////////////////////////////////////////////////////////
// Decode stage definitions: field widths, opcode digits, ALU, dispatch,
// skip and I/O codes, control flag indices and the instruction word views
////////////////////////////////////////////////////////////////////////////

package decodePkg;

	localparam int wordWidth = 36;                  // Machine word
	localparam int opWidth = 9;                     // Three octal digits
	localparam int dispWidth = 5;
	localparam int aluWidth = 5;
	localparam int condWidth = 3;
	localparam int ioOpWidth = 3;

	// Top octal digit of the opcode
	localparam logic [2:0] topUuo = 3'o0;
	localparam logic [2:0] topFloat = 3'o1;          // Not decoded here
	localparam logic [2:0] topMoveArith = 3'o2;
	localparam logic [2:0] topSkipJump = 3'o3;
	localparam logic [2:0] topBoolean = 3'o4;
	localparam logic [2:0] topHalfWord = 3'o5;       // Not decoded here
	localparam logic [2:0] topTest = 3'o6;
	localparam logic [2:0] ioGroup = 3'o7;           // All ones marks an I/O word

	// Middle digit inside the 2xx block
	localparam logic [2:0] midMoveLo = 3'o0;         // MOVE, MOVS
	localparam logic [2:0] midMoveHi = 3'o1;         // MOVN, MOVM
	localparam logic [2:0] midMulLo = 3'o2;          // IMUL, MUL
	localparam logic [2:0] midMulHi = 3'o3;          // IDIV, DIV
	localparam logic [2:0] midAddSub = 3'o7;

	// Low two opcode bits
	localparam logic [1:0] modeBasic = 2'd0;
	localparam logic [1:0] modeImm = 2'd1;
	localparam logic [1:0] modeMem = 2'd2;
	localparam logic [1:0] modeBoth = 2'd3;          // S for moves, B elsewhere

	// State machine dispatch
	localparam logic [dispWidth-1:0] dispCommon = 5'd0;
	localparam logic [dispWidth-1:0] dispMuuo = 5'd1;
	localparam logic [dispWidth-1:0] dispUnassigned = 5'd2;
	localparam logic [dispWidth-1:0] dispIMul = 5'd3;
	localparam logic [dispWidth-1:0] dispMul = 5'd4;
	localparam logic [dispWidth-1:0] dispIDiv = 5'd5;
	localparam logic [dispWidth-1:0] dispDiv = 5'd6;
	localparam logic [dispWidth-1:0] dispTest = 5'd7;
	localparam logic [dispWidth-1:0] dispIoRead = 5'd8;
	localparam logic [dispWidth-1:0] dispIoWrite = 5'd9;

	// Boolean codes follow the opcode order, so the function field is the code
	localparam logic [aluWidth-1:0] aluSetz = 5'd0;
	localparam logic [aluWidth-1:0] aluAnd = 5'd1;
	localparam logic [aluWidth-1:0] aluAndca = 5'd2;
	localparam logic [aluWidth-1:0] aluSetm = 5'd3;
	localparam logic [aluWidth-1:0] aluAndcm = 5'd4;
	localparam logic [aluWidth-1:0] aluSeta = 5'd5;
	localparam logic [aluWidth-1:0] aluXor = 5'd6;
	localparam logic [aluWidth-1:0] aluIor = 5'd7;
	localparam logic [aluWidth-1:0] aluAndcb = 5'd8;
	localparam logic [aluWidth-1:0] aluEqv = 5'd9;
	localparam logic [aluWidth-1:0] aluSetca = 5'd10;
	localparam logic [aluWidth-1:0] aluOrca = 5'd11;
	localparam logic [aluWidth-1:0] aluSetcm = 5'd12;
	localparam logic [aluWidth-1:0] aluOrcm = 5'd13;
	localparam logic [aluWidth-1:0] aluOrcb = 5'd14;
	localparam logic [aluWidth-1:0] aluSeto = 5'd15;
	localparam logic [aluWidth-1:0] aluAdd = 5'd16;
	localparam logic [aluWidth-1:0] aluSub = 5'd17;
	localparam logic [aluWidth-1:0] aluNegate = 5'd18;
	localparam logic [aluWidth-1:0] aluMagnitude = 5'd19;

	// Same as the low digit of the 3xx opcodes
	localparam logic [condWidth-1:0] skipNever = 3'd0;
	localparam logic [condWidth-1:0] skipL = 3'd1;
	localparam logic [condWidth-1:0] skipE = 3'd2;
	localparam logic [condWidth-1:0] skipLe = 3'd3;
	localparam logic [condWidth-1:0] skipA = 3'd4;
	localparam logic [condWidth-1:0] skipGe = 3'd5;
	localparam logic [condWidth-1:0] skipN = 3'd6;
	localparam logic [condWidth-1:0] skipG = 3'd7;

	localparam logic [ioOpWidth-1:0] ioBlki = 3'd0;
	localparam logic [ioOpWidth-1:0] ioDatai = 3'd1;
	localparam logic [ioOpWidth-1:0] ioBlko = 3'd2;
	localparam logic [ioOpWidth-1:0] ioDatao = 3'd3;
	localparam logic [ioOpWidth-1:0] ioCono = 3'd4;
	localparam logic [ioOpWidth-1:0] ioConi = 3'd5;
	localparam logic [ioOpWidth-1:0] ioConsz = 3'd6;
	localparam logic [ioOpWidth-1:0] ioConso = 3'd7;

	// Bit positions in the control flag vector
	localparam int numFlags = 12;
	localparam int flReadE = 0;
	localparam int flReadAC = 1;
	localparam int flReadOne = 2;
	localparam int flReadMinusOne = 3;
	localparam int flMSwap = 4;
	localparam int flSetFlags = 5;
	localparam int flWriteE = 6;
	localparam int flWriteAC = 7;
	localparam int flWriteSelf = 8;                  // Write AC only when AC is nonzero
	localparam int flComp0 = 9;
	localparam int flJump = 10;
	localparam int flIoCond = 11;

	typedef struct packed {
		logic [opWidth-1:0] opcode;
		logic [3:0] ac;
		logic indirect;
		logic [3:0] index;
		logic [wordWidth/2-1:0] address;             // Right half word
	} instBasic;

	typedef struct packed {
		logic [2:0] group;
		logic [6:0] device;
		logic [ioOpWidth-1:0] ioOp;
		logic indirect;
		logic [3:0] index;
		logic [wordWidth/2-1:0] address;
	} instIo;

	typedef union packed {
		instBasic basic;
		instIo io;
	} instWord;

endpackage

/* source/instDecode.sv */
////////////////////////////////////////////////////////////////////////////
// Instruction decode stage top level: family decoders and output register
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module instDecode (
	input  logic clk,
	input  logic rstN,
	input  logic instLoad,
	input  decodePkg::instWord inst,
	input  logic user,                                 // Executive or user mode
	input  logic userIO,                               // I/O allowed in user mode
	output logic decodeValid,
	output logic [decodePkg::dispWidth-1:0] dispatch,
	output logic [decodePkg::aluWidth-1:0] aluOp,
	output logic readE,
	output logic readAC,
	output logic readOne,
	output logic readMinusOne,
	output logic mSwap,
	output logic setFlags,
	output logic writeE,
	output logic writeAC,
	output logic writeSelf,
	output logic [decodePkg::condWidth-1:0] condCode,
	output logic comp0,
	output logic jump,
	output logic ioConditions
);
	import decodePkg::*;

	logic [dispWidth-1:0] maDispatch, sjDispatch, blDispatch, btDispatch, ioDispatch;
	logic [aluWidth-1:0] maAluOp, sjAluOp, blAluOp, btAluOp, ioAluOp;
	logic [numFlags-1:0] maFlags, sjFlags, blFlags, btFlags, ioFlags;
	logic [condWidth-1:0] maCondCode, sjCondCode, blCondCode, btCondCode, ioCondCode;

	moveArithDecode uMoveArith (
		.inst(inst),
		.dispatch(maDispatch),
		.aluOp(maAluOp),
		.flags(maFlags),
		.condCode(maCondCode)
	);

	skipJumpDecode uSkipJump (
		.inst(inst),
		.dispatch(sjDispatch),
		.aluOp(sjAluOp),
		.flags(sjFlags),
		.condCode(sjCondCode)
	);

	booleanDecode uBoolean (
		.inst(inst),
		.dispatch(blDispatch),
		.aluOp(blAluOp),
		.flags(blFlags),
		.condCode(blCondCode)
	);

	bitTestDecode uBitTest (
		.inst(inst),
		.dispatch(btDispatch),
		.aluOp(btAluOp),
		.flags(btFlags),
		.condCode(btCondCode)
	);

	ioDecode uIo (
		.inst(inst),
		.user(user),
		.userIO(userIO),
		.dispatch(ioDispatch),
		.aluOp(ioAluOp),
		.flags(ioFlags),
		.condCode(ioCondCode)
	);

	decodeOutputReg uOutputReg (
		.clk, .rstN, .instLoad, .inst,
		.maDispatch, .maAluOp, .maFlags, .maCondCode,
		.sjDispatch, .sjAluOp, .sjFlags, .sjCondCode,
		.blDispatch, .blAluOp, .blFlags, .blCondCode,
		.btDispatch, .btAluOp, .btFlags, .btCondCode,
		.ioDispatch, .ioAluOp, .ioFlags, .ioCondCode,
		.decodeValid, .dispatch, .aluOp,
		.readE, .readAC, .readOne, .readMinusOne, .mSwap, .setFlags,
		.writeE, .writeAC, .writeSelf,
		.condCode, .comp0, .jump, .ioConditions
	);

endmodule

/* source/ioDecode.sv */
////////////////////////////////////////////////////////////////////////////
// Decoder for 7xx I/O instructions with user-mode trapping
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module ioDecode (
	input  decodePkg::instWord inst,
	input  logic user,
	input  logic userIO,
	output logic [decodePkg::dispWidth-1:0] dispatch,
	output logic [decodePkg::aluWidth-1:0] aluOp,
	output logic [decodePkg::numFlags-1:0] flags,
	output logic [decodePkg::condWidth-1:0] condCode
);
	import decodePkg::*;

	always_comb begin
		dispatch = dispUnassigned;
		aluOp = aluSetz;
		flags = '0;
		condCode = skipNever;
		if (user && !userIO) begin
			dispatch = dispMuuo;                       // Trap to the monitor
		end else begin
			case (inst.io.ioOp)
				ioCono: begin
					dispatch = dispIoWrite;
					flags[flIoCond] = 1'b1;
				end
				ioConi: begin
					dispatch = dispIoRead;
					flags[flWriteE] = 1'b1;
					flags[flIoCond] = 1'b1;
				end
				ioConsz, ioConso: begin
					dispatch = dispIoRead;
					aluOp = inst.io.ioOp[0] ? aluIor : aluAnd;
					condCode = inst.io.ioOp[0] ? skipN : skipE;
					flags[flComp0] = 1'b1;
					flags[flIoCond] = 1'b1;
				end
				ioDatao: begin
					dispatch = dispIoWrite;
					aluOp = aluSetm;
					flags[flReadE] = 1'b1;
				end
				ioDatai: begin
					dispatch = dispIoRead;
					flags[flWriteE] = 1'b1;
				end
				ioBlki, ioBlko: dispatch = dispUnassigned;  // Block transfers not supported
				default: dispatch = dispUnassigned;
			endcase
		end
	end

endmodule

/* source/moveArithDecode.sv */
////////////////////////////////////////////////////////////////////////////
// Decoder for the 2xx block: full-word moves, multiply and divide
// dispatch, ADD and SUB
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module moveArithDecode (
	input  decodePkg::instWord inst,
	output logic [decodePkg::dispWidth-1:0] dispatch,
	output logic [decodePkg::aluWidth-1:0] aluOp,
	output logic [decodePkg::numFlags-1:0] flags,
	output logic [decodePkg::condWidth-1:0] condCode
);
	import decodePkg::*;

	logic [2:0] midDigit;
	logic [1:0] func;
	logic [1:0] mode;
	logic [numFlags-1:0] arithFlags;                   // Mode rule shared by mul/div and add/sub

	assign midDigit = inst.basic.opcode[5:3];
	assign func = inst.basic.opcode[3:2];
	assign mode = inst.basic.opcode[1:0];
	assign condCode = skipNever;                       // Nothing here skips

	always_comb begin
		arithFlags = '0;
		arithFlags[flSetFlags] = 1'b1;
		arithFlags[flReadE] = (mode != modeImm);
		arithFlags[flWriteE] = mode[1];                // M and B
		arithFlags[flWriteAC] = (mode != modeMem);
	end

	always_comb begin
		dispatch = dispCommon;
		aluOp = aluSetz;
		flags = '0;
		case (midDigit)
			midMoveLo, midMoveHi: begin
				case (func)
					2'd0: aluOp = aluSetm;             // MOVE
					2'd1: begin                        // MOVS
						aluOp = aluSetm;
						flags[flMSwap] = 1'b1;
					end
					2'd2: aluOp = aluNegate;           // MOVN
					default: aluOp = aluMagnitude;     // MOVM
				endcase
				flags[flSetFlags] = 1'b1;
				case (mode)
					modeBasic: begin
						flags[flReadE] = 1'b1;
						flags[flWriteAC] = 1'b1;
					end
					modeImm: flags[flWriteAC] = 1'b1;  // Operand is 0,E so E is never read
					modeMem: begin
						flags[flReadAC] = 1'b1;
						flags[flWriteE] = 1'b1;
					end
					default: begin                     // Self
						flags[flReadE] = 1'b1;
						flags[flWriteE] = 1'b1;
						flags[flWriteSelf] = 1'b1;
					end
				endcase
			end
			midMulLo, midMulHi: begin
				case (func)
					2'd0: dispatch = dispIMul;
					2'd1: dispatch = dispMul;
					2'd2: dispatch = dispIDiv;
					default: dispatch = dispDiv;
				endcase
				flags = arithFlags;
			end
			midAddSub: begin
				aluOp = inst.basic.opcode[2] ? aluSub : aluAdd;
				flags = arithFlags;
			end
			default: dispatch = dispUnassigned;        // Shifts, stack, jumps
		endcase
	end

endmodule

/* source/skipJumpDecode.sv */
////////////////////////////////////////////////////////////////////////////
// Decoder for the 3xx block: compare, jump, skip and the add-one and
// subtract-one jump and skip groups
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module skipJumpDecode (
	input  decodePkg::instWord inst,
	output logic [decodePkg::dispWidth-1:0] dispatch,
	output logic [decodePkg::aluWidth-1:0] aluOp,
	output logic [decodePkg::numFlags-1:0] flags,
	output logic [decodePkg::condWidth-1:0] condCode
);
	import decodePkg::*;

	logic [2:0] group;

	assign group = inst.basic.opcode[5:3];
	assign condCode = inst.basic.opcode[2:0];          // Low digit is the condition
	assign dispatch = dispCommon;

	always_comb begin
		aluOp = aluAdd;
		flags = '0;
		if (group[2]) begin                            // AOJ AOS SOJ SOS
			flags[flSetFlags] = 1'b1;
			flags[flReadOne] = ~group[1];
			flags[flReadMinusOne] = group[1];          // Adding -1 keeps the carries right
			if (group[0]) begin                        // Memory form skips
				flags[flReadE] = 1'b1;
				flags[flWriteE] = 1'b1;
				flags[flWriteSelf] = 1'b1;
				flags[flComp0] = 1'b1;
			end else begin                             // AC form jumps
				flags[flReadAC] = 1'b1;
				flags[flWriteAC] = 1'b1;
				flags[flJump] = 1'b1;
			end
		end else begin
			case (group[1:0])
				2'd0: aluOp = aluSub;                  // CAI
				2'd1: begin                            // CAM
					aluOp = aluSub;
					flags[flReadE] = 1'b1;
				end
				2'd2: begin                            // JUMP
					aluOp = aluSetm;
					flags[flReadAC] = 1'b1;
					flags[flComp0] = 1'b1;
					flags[flJump] = 1'b1;
				end
				default: begin                         // SKIP
					aluOp = aluSetm;
					flags[flReadE] = 1'b1;
					flags[flWriteSelf] = 1'b1;
					flags[flComp0] = 1'b1;
				end
			endcase
		end
	end

endmodule

/* verification/instDecodeSva.sv */
////////////////////////////////////////////////////////////////////////////
// Assertions bound to the decode stage: valid timing, output hold and
// reset state
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module instDecodeSva (
	input logic clk,
	input logic rstN,
	input logic instLoad,
	input logic decodeValid,
	input logic [decodePkg::dispWidth-1:0] dispatch,
	input logic [decodePkg::aluWidth-1:0] aluOp,
	input logic readE,
	input logic readAC,
	input logic readOne,
	input logic readMinusOne,
	input logic mSwap,
	input logic setFlags,
	input logic writeE,
	input logic writeAC,
	input logic writeSelf,
	input logic [decodePkg::condWidth-1:0] condCode,
	input logic comp0,
	input logic jump,
	input logic ioConditions
);
	logic [11:0] flagBits;
	logic [24:0] controls;
	int failCount = 0;                                 // Read by the testbench at the end

	assign flagBits = {ioConditions, jump, comp0, writeSelf, writeAC, writeE, setFlags, mSwap,
		readMinusOne, readOne, readAC, readE};
	assign controls = {dispatch, aluOp, flagBits, condCode};

	validAfterLoad: assert property (@(posedge clk) disable iff (!rstN)
		instLoad |=> decodeValid)
		else begin
			$error("decodeValid missing in the cycle after a load");
			failCount++;
		end

	noValidWithoutLoad: assert property (@(posedge clk) disable iff (!rstN)
		!instLoad |=> !decodeValid)
		else begin
			$error("decodeValid high without a load");
			failCount++;
		end

	holdWithoutLoad: assert property (@(posedge clk) disable iff (!rstN)
		!instLoad |=> $stable(controls))
		else begin
			$error("decoded controls changed without a load");
			failCount++;
		end

	// Sampled on the falling edge so the first reset edge has settled
	resetState: assert property (@(negedge clk) !rstN |-> (flagBits == '0 && !decodeValid))
		else begin
			$error("flags or decodeValid not clear during reset");
			failCount++;
		end

endmodule

bind instDecode instDecodeSva svaChecks (.*);

/* verification/instDecodeTb.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench for the decode stage: clock, reset, random instruction loads,
// reference decode model, output checks and watchdog
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module instDecodeTb;
	import decodePkg::*;

	localparam int clkPeriod = 4;
	localparam int resetCycles = 16;
	localparam int numLoads = 3000;
	localparam int seed = 12;
	localparam int watchdogTime = numLoads * 4 * clkPeriod + resetCycles * clkPeriod;

	logic clk;
	logic rstN;
	logic instLoad;
	instWord inst;
	logic user;
	logic userIO;
	logic decodeValid;
	logic [dispWidth-1:0] dispatch;
	logic [aluWidth-1:0] aluOp;
	logic readE;
	logic readAC;
	logic readOne;
	logic readMinusOne;
	logic mSwap;
	logic setFlags;
	logic writeE;
	logic writeAC;
	logic writeSelf;
	logic [condWidth-1:0] condCode;
	logic comp0;
	logic jump;
	logic ioConditions;

	// Expected controls packed as dispatch, ALU, flags, condition
	logic [24:0] pending[$];
	logic [24:0] held;
	logic expValid;
	int errorCount;
	int loadCount;

	instDecode dut_i (.*);

	// Starts high so the first falling edge comes after reset is applied
	initial begin
		clk = 1'b1;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	// Read and write flags shared by mul/div, ADD/SUB and the boolean group
	function automatic logic [numFlags-1:0] arithModeFlags(input logic [1:0] mode);
		logic [numFlags-1:0] fl;
		fl = '0;
		case (mode)
			modeBasic: begin
				fl[flReadE] = 1'b1;
				fl[flWriteAC] = 1'b1;
			end
			modeImm: fl[flWriteAC] = 1'b1;
			modeMem: begin
				fl[flReadE] = 1'b1;
				fl[flWriteE] = 1'b1;
			end
			default: begin
				fl[flReadE] = 1'b1;
				fl[flWriteE] = 1'b1;
				fl[flWriteAC] = 1'b1;
			end
		endcase
		return fl;
	endfunction

	function automatic logic [24:0] modelDecode(input logic [35:0] word, input logic usr,
			input logic usrIo);
		logic [8:0] op;
		logic [2:0] ioOp;
		logic [dispWidth-1:0] disp;
		logic [aluWidth-1:0] alu;
		logic [numFlags-1:0] fl;
		logic [condWidth-1:0] cond;
		op = word[35:27];
		ioOp = word[25:23];                           // Field after group and device
		disp = dispCommon;
		alu = aluSetz;
		fl = '0;
		cond = skipNever;
		case (op[8:6])
			3'o0: disp = dispMuuo;
			3'o2: begin
				if (op <= 9'o217) begin              // MOVE MOVS MOVN MOVM
					case (op[3:2])
						2'd0: alu = aluSetm;
						2'd1: begin
							alu = aluSetm;
							fl[flMSwap] = 1'b1;
						end
						2'd2: alu = aluNegate;
						default: alu = aluMagnitude;
					endcase
					case (op[1:0])
						modeBasic: begin
							fl[flReadE] = 1'b1;
							fl[flWriteAC] = 1'b1;
						end
						modeImm: fl[flWriteAC] = 1'b1;
						modeMem: begin
							fl[flReadAC] = 1'b1;
							fl[flWriteE] = 1'b1;
						end
						default: begin
							fl[flReadE] = 1'b1;
							fl[flWriteE] = 1'b1;
							fl[flWriteSelf] = 1'b1;
						end
					endcase
					fl[flSetFlags] = 1'b1;
				end else if (op <= 9'o237) begin     // IMUL MUL IDIV DIV
					case (op[3:2])
						2'd0: disp = dispIMul;
						2'd1: disp = dispMul;
						2'd2: disp = dispIDiv;
						default: disp = dispDiv;
					endcase
					fl = arithModeFlags(op[1:0]);
					fl[flSetFlags] = 1'b1;
				end else if (op >= 9'o270) begin
					alu = (op >= 9'o274) ? aluSub : aluAdd;
					fl = arithModeFlags(op[1:0]);
					fl[flSetFlags] = 1'b1;
				end else begin
					disp = dispUnassigned;
				end
			end
			3'o3: begin
				cond = op[2:0];
				case (op[5:3])
					3'd0: alu = aluSub;
					3'd1: begin
						alu = aluSub;
						fl[flReadE] = 1'b1;
					end
					3'd2: begin
						alu = aluSetm;
						fl[flReadAC] = 1'b1;
						fl[flComp0] = 1'b1;
						fl[flJump] = 1'b1;
					end
					3'd3: begin
						alu = aluSetm;
						fl[flReadE] = 1'b1;
						fl[flWriteSelf] = 1'b1;
						fl[flComp0] = 1'b1;
					end
					3'd4, 3'd6: begin                // AOJ SOJ
						alu = aluAdd;
						fl[flReadAC] = 1'b1;
						fl[flWriteAC] = 1'b1;
						fl[flSetFlags] = 1'b1;
						fl[flJump] = 1'b1;
					end
					default: begin                   // AOS SOS
						alu = aluAdd;
						fl[flReadE] = 1'b1;
						fl[flWriteE] = 1'b1;
						fl[flWriteSelf] = 1'b1;
						fl[flSetFlags] = 1'b1;
						fl[flComp0] = 1'b1;
					end
				endcase
				fl[flReadOne] = (op[5:3] == 3'd4) || (op[5:3] == 3'd5);
				fl[flReadMinusOne] = (op[5:3] == 3'd6) || (op[5:3] == 3'd7);
			end
			3'o4: begin
				alu = {1'b0, op[5:2]};
				fl = arithModeFlags(op[1:0]);
			end
			3'o6: begin
				disp = dispTest;
				fl[flMSwap] = op[0];
				fl[flReadE] = op[3];
				case (op[2:1])
					2'd0: cond = skipNever;
					2'd1: cond = skipE;
					2'd2: cond = skipA;
					default: cond = skipN;
				endcase
				case (op[5:4])
					2'd0: alu = aluSeta;
					2'd1: alu = aluAndcm;
					2'd2: alu = aluXor;
					default: alu = aluIor;
				endcase
				fl[flWriteAC] = (op[5:4] != 2'd0);
			end
			3'o7: begin
				if (usr && !usrIo) begin
					disp = dispMuuo;
				end else begin
					case (ioOp)
						ioCono: begin
							disp = dispIoWrite;
							fl[flIoCond] = 1'b1;
						end
						ioConi: begin
							disp = dispIoRead;
							fl[flWriteE] = 1'b1;
							fl[flIoCond] = 1'b1;
						end
						ioConsz: begin
							disp = dispIoRead;
							alu = aluAnd;
							cond = skipE;
							fl[flComp0] = 1'b1;
							fl[flIoCond] = 1'b1;
						end
						ioConso: begin
							disp = dispIoRead;
							alu = aluIor;
							cond = skipN;
							fl[flComp0] = 1'b1;
							fl[flIoCond] = 1'b1;
						end
						ioDatao: begin
							disp = dispIoWrite;
							alu = aluSetm;
							fl[flReadE] = 1'b1;
						end
						ioDatai: begin
							disp = dispIoRead;
							fl[flWriteE] = 1'b1;
						end
						default: disp = dispUnassigned;
					endcase
				end
			end
			default: disp = dispUnassigned;          // 1xx and 5xx
		endcase
		return {disp, alu, fl, cond};
	endfunction

	// Weighted toward the decoded families
	function automatic logic [8:0] randomOpcode();
		int pick;
		logic [5:0] low;
		pick = $urandom_range(0, 99);
		low = $urandom_range(0, 63);
		if (pick < 8)
			return {3'o0, low};
		else if (pick < 12)
			return {3'o1, low};
		else if (pick < 32)
			return {3'o2, low};
		else if (pick < 50)
			return {3'o3, low};
		else if (pick < 64)
			return {3'o4, low};
		else if (pick < 68)
			return {3'o5, low};
		else if (pick < 82)
			return {3'o6, low};
		else
			return {3'o7, low};
	endfunction

	task automatic checkField(input string name, input logic [7:0] actual,
			input logic [7:0] expected);
		if (actual !== expected) begin
			errorCount++;
			$display("mismatch at %0t ns: %s is %0h, expected %0h", $time, name, actual,
				expected);
		end
	endtask

	task automatic compareOutputs();
		logic [numFlags-1:0] fl;
		fl = held[14:3];
		checkField("decodeValid", decodeValid, expValid);
		checkField("dispatch", dispatch, held[24:20]);
		checkField("aluOp", aluOp, held[19:15]);
		checkField("condCode", condCode, held[2:0]);
		checkField("readE", readE, fl[flReadE]);
		checkField("readAC", readAC, fl[flReadAC]);
		checkField("readOne", readOne, fl[flReadOne]);
		checkField("readMinusOne", readMinusOne, fl[flReadMinusOne]);
		checkField("mSwap", mSwap, fl[flMSwap]);
		checkField("setFlags", setFlags, fl[flSetFlags]);
		checkField("writeE", writeE, fl[flWriteE]);
		checkField("writeAC", writeAC, fl[flWriteAC]);
		checkField("writeSelf", writeSelf, fl[flWriteSelf]);
		checkField("comp0", comp0, fl[flComp0]);
		checkField("jump", jump, fl[flJump]);
		checkField("ioConditions", ioConditions, fl[flIoCond]);
	endtask

	// One clock: check what the last edge produced, then drive new inputs
	task automatic runCycle(input logic doLoad);
		logic [31:0] rest;
		logic [31:0] modeBits;
		logic [35:0] word;
		@(negedge clk);
		if (pending.size() > 0) begin
			held = pending.pop_front();
			expValid = 1'b1;
		end else begin
			expValid = 1'b0;                          // Outputs must hold
		end
		compareOutputs();
		rest = $urandom;
		modeBits = $urandom;
		word = {randomOpcode(), rest[26:0]};
		inst = word;
		user = modeBits[0];
		userIO = modeBits[1];
		instLoad = doLoad;
		if (doLoad)
			pending.push_back(modelDecode(word, modeBits[0], modeBits[1]));
	endtask

	initial begin
		void'($urandom(seed));
		errorCount = 0;
		rstN = 1'b0;
		instLoad = 1'b0;
		inst = '0;
		user = 1'b0;
		userIO = 1'b0;
		held = {dispCommon, aluSetz, {numFlags{1'b0}}, skipNever};
		expValid = 1'b0;
		repeat (resetCycles) runCycle(1'b0);
		rstN = 1'b1;
		repeat (4) runCycle(1'b0);                   // Reset values before any load
		for (loadCount = 0; loadCount < numLoads; loadCount++) begin
			runCycle(1'b1);
			if ($urandom_range(0, 3) == 0)
				repeat ($urandom_range(1, 2)) runCycle(1'b0);
		end
		repeat (4) runCycle(1'b0);
		$display("Run finished after %0d loads with %0d mismatches and %0d assertion failures",
			loadCount, errorCount, dut_i.svaChecks.failCount);
		if (errorCount == 0 && dut_i.svaChecks.failCount == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	initial begin
		#(watchdogTime);
		$display("Timeout: the run did not end within %0d ns, %0d errors so far",
			watchdogTime, errorCount);
		$display("TEST FAILED");
		$finish;
	end

endmodule
